/* Bender.yml */
package:
  name: st_mem_glue

sources:
  - hw/st_mem_pkg.sv
  - hw/tos_loader.sv
  - hw/viking_detect.sv
  - hw/sdram_arbiter.sv
  - hw/st_mem_glue.sv
  - target: test
    files:
      - tb/tb_st_mem_glue.sv

/* flist.f */
hw/st_mem_pkg.sv
hw/tos_loader.sv
hw/viking_detect.sv
hw/sdram_arbiter.sv
hw/st_mem_glue.sv
tb/tb_st_mem_glue.sv

/* hw/sdram_arbiter.sv */
`default_nettype none

module sdram_arbiter
	import st_mem_pkg::*;
(
	input  wire logic            clk_32,
	input  wire logic            xsint,
	input  wire sys_cfg_t        cfg_i,
	input  wire bus_slot_e       slot_i,
	input  wire mmu_req_t        mmu_i,
	input  wire master_req_t     master_i,
	input  wire upload_t         upload_i,
	input  wire logic            upload_wr_i,
	input  wire logic            viking_active_i,
	input  wire logic            viking_read_i,
	input  wire logic [ADDR_W:1] viking_addr_i,
	output sdram_req_t           sdram_o
);

	logic ras_n_d;
	logic ras_fall; // start of an mmu ram cycle
	logic mmu_rd;
	logic mmu_wr;
	logic ram_en;   // mmu address inside configured st ram
	logic cpu_cycle;
	logic vid_cycle;
	logic up_sel;
	logic mst_sel;
	logic vik_sel;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_d <= 1'b1; // idle high so no fake edge is seen
		else
			ras_n_d <= mmu_i.ras_n;
	end

	assign ras_fall = ras_n_d && !mmu_i.ras_n;
	assign mmu_rd   = ras_fall && mmu_i.we_n && (|mmu_i.addr); // address 0 is never read here
	assign mmu_wr   = ras_fall && !mmu_i.we_n;

	// ram size window
	always_comb begin
		case (cfg_i.mem_size)
			MEM_512K: ram_en = (mmu_i.addr[ADDR_W -: 5] == '0);
			MEM_1M:   ram_en = (mmu_i.addr[ADDR_W -: 4] == '0);
			MEM_2M:   ram_en = (mmu_i.addr[ADDR_W -: 3] == '0);
			MEM_4M:   ram_en = (mmu_i.addr[ADDR_W -: 2] == '0);
			MEM_8M:   ram_en = !mmu_i.addr[ADDR_W];
			MEM_14M:  ram_en = (mmu_i.addr[ADDR_W -: 3] != 3'b111); // below $e00000
			default:  ram_en = 1'b0;
		endcase
	end

	assign cpu_cycle = (slot_i == SLOT_CPU);
	assign vid_cycle = (slot_i == SLOT_VID); // shared with the shifter

	assign up_sel  = cpu_cycle && upload_i.download;
	assign mst_sel = cpu_cycle && master_i.has_bus;
	assign vik_sel = vid_cycle && viking_active_i && viking_read_i;

	always_comb begin
		// address
		if (up_sel)
			sdram_o.addr = upload_i.addr;
		else if (mst_sel)
			sdram_o.addr = master_i.addr;
		else if (vik_sel)
			sdram_o.addr = viking_addr_i;
		else
			sdram_o.addr = mmu_i.addr;

		// read
		if (up_sel)
			sdram_o.oe = 1'b0; // upload only writes
		else if (cpu_cycle && master_i.read)
			sdram_o.oe = 1'b1;
		else if (vik_sel)
			sdram_o.oe = 1'b1;
		else
			sdram_o.oe = mmu_rd && ram_en;

		// write
		if (up_sel)
			sdram_o.we = upload_wr_i;
		else if (cpu_cycle && master_i.write)
			sdram_o.we = 1'b1;
		else
			sdram_o.we = mmu_wr && ram_en;

		// data is not slot qualified
		if (upload_i.download)
			sdram_o.wdata = upload_i.data;
		else if (master_i.has_bus)
			sdram_o.wdata = master_i.wdata;
		else
			sdram_o.wdata = mmu_i.wdata;

		// upload and blitter always move whole words
		sdram_o.uds = (up_sel || mst_sel) ? 1'b1 : mmu_i.uds;
		sdram_o.lds = (up_sel || mst_sel) ? 1'b1 : mmu_i.lds;
	end

	a_oe_we_excl: assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_o.oe && sdram_o.we))
		else $error("sdram read and write requested in the same cycle");

endmodule

`default_nettype wire

/* hw/st_mem_glue.sv */
`default_nettype none

module st_mem_glue
	import st_mem_pkg::*;
#(
	parameter int VIKING_CNT_W = 8
) (
	input  wire logic            clk_32,
	input  wire logic            xsint,
	input  wire sys_cfg_t        cfg_i,
	input  wire bus_slot_e       slot_i,
	input  wire logic            mhz8_en_i,
	input  wire mmu_req_t        mmu_i,
	input  wire master_req_t     master_i,
	input  wire upload_t         upload_i,
	input  wire logic [ADDR_W:1] cpu_addr_i,
	input  wire logic            cpu_as_i,
	input  wire logic            rom2_sel_i,
	input  wire logic            viking_read_i,
	input  wire logic [ADDR_W:1] viking_addr_i,
	output wire sdram_req_t      sdram_o,
	output wire logic [ADDR_W:1] rom_addr_o,
	output wire logic            tos192k_o,
	output wire logic            viking_active_o
);

	wire logic upload_wr; // one clock per uploaded word

	tos_loader u_tos_loader (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.slot_i      (slot_i),
		.mhz8_en_i   (mhz8_en_i),
		.upload_i    (upload_i),
		.cpu_addr_i  (cpu_addr_i),
		.rom2_sel_i  (rom2_sel_i),
		.upload_wr_o (upload_wr),
		.tos192k_o   (tos192k_o),
		.rom_addr_o  (rom_addr_o)
	);

	viking_detect #(
		.VIKING_CNT_W (VIKING_CNT_W)
	) u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.mhz8_en_i       (mhz8_en_i),
		.cpu_as_i        (cpu_as_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_active_o (viking_active_o)
	);

	sdram_arbiter u_sdram_arbiter (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.slot_i          (slot_i),
		.mmu_i           (mmu_i),
		.master_i        (master_i),
		.upload_i        (upload_i),
		.upload_wr_i     (upload_wr),
		.viking_active_i (viking_active_o), // video fetch only once the driver runs
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.sdram_o         (sdram_o)
	);

endmodule

`default_nettype wire

/* hw/st_mem_pkg.sv */
`default_nettype none

package st_mem_pkg;

	localparam int ADDR_W = 23; // word address over bits 23..1
	localparam int DATA_W = 16;

	// bus slot as seen by the sdram port
	typedef enum logic [1:0] {
		SLOT_PRE = 2'd0, // cpu precycle
		SLOT_CPU = 2'd1, // cpu or bus master
		SLOT_VID = 2'd2  // shifter / video card fetch
	} bus_slot_e;

	// configured st ram where 6 and 7 mean no ram at all
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	typedef enum logic [1:0] {
		MODE_ST,
		MODE_STE,
		MODE_MSTE,
		MODE_STEROIDS // ste on steroids with viking moved to $e80000
	} mach_mode_e;

	typedef struct packed {
		mem_size_e  mem_size;
		mach_mode_e mode;
		logic       viking_req; // user asked for the viking card
	} sys_cfg_t;

	// ram cycle from the mmu side
	typedef struct packed {
		logic [ADDR_W:1]   addr;
		logic [DATA_W-1:0] wdata;
		logic              uds;
		logic              lds;
		logic              we_n;
		logic              ras_n; // ras0_n & ras1_n
	} mmu_req_t;

	// blitter while it owns the bus
	typedef struct packed {
		logic [ADDR_W:1]   addr;
		logic [DATA_W-1:0] wdata;
		logic              has_bus;
		logic              read;
		logic              write;
	} master_req_t;

	// rom/cart upload from the io controller
	typedef struct packed {
		logic [ADDR_W:1]   addr;
		logic [DATA_W-1:0] data;
		logic              download;
		logic              strobe_tgl; // flips once per word
	} upload_t;

	typedef struct packed {
		logic [ADDR_W:1]   addr;
		logic [DATA_W-1:0] wdata;
		logic              uds;
		logic              lds;
		logic              we;
		logic              oe;
	} sdram_req_t;

	localparam logic [5:0] VIKING_BASE_LO = 6'b110000; // $c0xxxx
	localparam logic [5:0] VIKING_BASE_HI = 6'b111010; // $e80000
	localparam logic [5:0] TOS192_PREFIX  = 6'b111111; // 192k tos at $fc0000
	localparam logic [3:0] TOS_HI_PREFIX  = 4'he;      // 256k tos at $e00000

endpackage

`default_nettype wire

/* hw/tos_loader.sv */
`default_nettype none

module tos_loader
	import st_mem_pkg::*;
(
	input  wire logic            clk_32,
	input  wire logic            xsint,
	input  wire bus_slot_e       slot_i,
	input  wire logic            mhz8_en_i,
	input  wire upload_t         upload_i,
	input  wire logic [ADDR_W:1] cpu_addr_i,
	input  wire logic            rom2_sel_i,
	output logic                 upload_wr_o,
	output logic                 tos192k_o,
	output logic      [ADDR_W:1] rom_addr_o
);

	logic strobe_d; // strobe as last seen in a precycle
	logic tos192k;
	logic pre_phase;

	// sample only in the cpu precycle so the write lands in the next cpu slot
	assign pre_phase = (slot_i == SLOT_PRE) && mhz8_en_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d    <= 1'b0;
			upload_wr_o <= 1'b0;
			tos192k     <= 1'b0;
		end else begin
			upload_wr_o <= 1'b0; // single pulse
			if (pre_phase) begin
				strobe_d <= upload_i.strobe_tgl;
				if (upload_i.strobe_tgl != strobe_d)
					upload_wr_o <= 1'b1; // new word from io controller
			end
			// tos size follows where the image is being loaded
			if (upload_i.download) begin
				if (upload_i.addr[ADDR_W -: 6] == TOS192_PREFIX)
					tos192k <= 1'b1;
				else if (upload_i.addr[ADDR_W -: 4] == TOS_HI_PREFIX)
					tos192k <= 1'b0;
			end
		end
	end

	assign tos192k_o = tos192k;

	// rom2 window mapped onto the uploaded image
	always_comb begin
		rom_addr_o = cpu_addr_i;
		if (rom2_sel_i) begin
			if (tos192k)
				rom_addr_o = {4'hf, 2'b11, cpu_addr_i[17:1]}; // $fc0000
			else
				rom_addr_o = {4'he, 2'b00, cpu_addr_i[17:1]}; // $e00000
		end
	end

	// a write strobe never covers two sdram slots
	a_wr_single: assert property (@(posedge clk_32) disable iff (!xsint)
		upload_wr_o |=> !upload_wr_o)
		else $error("upload write pulse longer than one clock");

endmodule

`default_nettype wire

/* hw/viking_detect.sv */
`default_nettype none

module viking_detect
	import st_mem_pkg::*;
#(
	parameter int VIKING_CNT_W = 8
) (
	input  wire logic            clk_32,
	input  wire logic            xsint,
	input  wire sys_cfg_t        cfg_i,
	input  wire logic            mhz8_en_i,
	input  wire logic            cpu_as_i,
	input  wire logic [ADDR_W:1] cpu_addr_i,
	output logic                 viking_active_o
);

	logic                    steroids;
	logic                    mem_ok;
	logic                    viking_en;
	logic [5:0]              base;
	logic                    hit;
	logic [VIKING_CNT_W-1:0] hit_cnt; // saturating access counter

	assign steroids = (cfg_i.mode == MODE_STEROIDS);
	// card limits st ram to 8M unless video mem sits high
	assign mem_ok = cfg_i.mem_size inside {MEM_512K, MEM_1M, MEM_2M, MEM_4M, MEM_8M};
	assign viking_en = (cfg_i.viking_req && mem_ok) || steroids;
	assign base = steroids ? VIKING_BASE_HI : VIKING_BASE_LO;

	// one hit per 8 MHz phase of a cpu access to the card window
	assign hit = mhz8_en_i && cpu_as_i && viking_en && (cpu_addr_i[ADDR_W -: 6] == base);

	// many accesses mean the driver is running, a single probe does not count
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit && (hit_cnt != '1))
				hit_cnt <= hit_cnt + 1'b1;
			viking_active_o <= (hit_cnt == '1); // one clock behind the count
		end
	end

	a_active_cnt: assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_o |-> (hit_cnt == '1))
		else $error("viking active before hit counter saturated");

endmodule

`default_nettype wire

/* tb/tb_st_mem_glue.sv */
`default_nettype none

module tb_st_mem_glue
	import st_mem_pkg::*;
();

	logic            clk_32;
	logic            xsint;
	sys_cfg_t        cfg;
	bus_slot_e       slot;
	logic            mhz8_en;
	mmu_req_t        mmu;
	master_req_t     master;
	upload_t         upload;
	logic [ADDR_W:1] cpu_addr;
	logic            cpu_as;
	logic            rom2_sel;
	logic            viking_read;
	logic [ADDR_W:1] viking_addr;
	sdram_req_t      sdram;
	logic [ADDR_W:1] rom_addr;
	logic            tos192k;
	logic            viking_active;
	integer          seed;

	st_mem_glue #(.VIKING_CNT_W(8)) dut (
		.clk_32 (clk_32), .xsint (xsint), .cfg_i (cfg), .slot_i (slot),
		.mhz8_en_i (mhz8_en), .mmu_i (mmu), .master_i (master), .upload_i (upload),
		.cpu_addr_i (cpu_addr), .cpu_as_i (cpu_as), .rom2_sel_i (rom2_sel),
		.viking_read_i (viking_read), .viking_addr_i (viking_addr), .sdram_o (sdram),
		.rom_addr_o (rom_addr), .tos192k_o (tos192k), .viking_active_o (viking_active)
	);

	initial begin
		clk_32 = 1'b0;
		forever #5 clk_32 = ~clk_32;
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
			$display("sim failed");
			$fatal(1, "check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$fatal(1, "wait expired");
	endtask

	task automatic apply_reset();
		xsint <= 1'b0;
		repeat (4) @(posedge clk_32);
		xsint <= 1'b1;
		@(posedge clk_32);
	endtask

	// leading address bits that must be zero for each ram size
	function automatic logic [ADDR_W:1] window_mask(input int sz);
		logic [ADDR_W:1] m;
		m = '1;
		m = m >> ((sz < 5) ? (5 - sz) : 2); // two bits for 14M so bit 23 can be set alone
		return m;
	endfunction

	task automatic upload_test();
		logic [ADDR_W:1]   a;
		logic [DATA_W-1:0] d;
		a = $random(seed);
		d = $random(seed);
		@(posedge clk_32);
		upload.download   <= 1'b1;
		upload.addr       <= a;
		upload.data       <= d;
		upload.strobe_tgl <= ~upload.strobe_tgl; // new word
		master            <= '{addr: ~a, wdata: ~d, has_bus: 1'b1, read: 1'b0, write: 1'b1};
		slot              <= SLOT_PRE;
		mhz8_en           <= 1'b1;
		@(posedge clk_32);
		slot    <= SLOT_CPU; // write pulse lands here
		mhz8_en <= 1'b0;
		@(negedge clk_32);
		check(sdram.we, 1'b1, "upload write missing");
		check(sdram.oe, 1'b0, "upload read strobe");
		check(sdram.addr, a, "upload address");
		check(sdram.wdata, d, "upload data");
		check({sdram.uds, sdram.lds}, 2'b11, "upload byte strobes");
		@(negedge clk_32);
		check(sdram.we, 1'b0, "upload write longer than one cycle"); // master still loses
		// precycle again with the strobe unchanged
		@(posedge clk_32);
		slot    <= SLOT_PRE;
		mhz8_en <= 1'b1;
		@(posedge clk_32);
		slot    <= SLOT_CPU;
		mhz8_en <= 1'b0;
		@(negedge clk_32);
		check(sdram.we, 1'b0, "upload write without strobe toggle");
		@(posedge clk_32);
		upload.download <= 1'b0;
		master          <= '0;
		slot            <= SLOT_VID;
	endtask

	task automatic tos_flag_test(input logic [5:0] prefix, input logic exp_flag);
		logic [ADDR_W:1] ca;
		logic [16:0]     r17;
		ca  = $random(seed);
		r17 = $random(seed);
		@(posedge clk_32);
		upload.download <= 1'b1;
		upload.addr     <= {prefix, r17};
		@(posedge clk_32);
		upload.download <= 1'b0;
		rom2_sel        <= 1'b1;
		cpu_addr        <= ca;
		@(negedge clk_32);
		check(tos192k, exp_flag, "192k tos flag");
		if (exp_flag)
			check(rom_addr, {4'hf, 2'b11, ca[17:1]}, "rom2 remap with 192k tos");
		else
			check(rom_addr, {4'he, 2'b00, ca[17:1]}, "rom2 remap with 256k tos");
		@(posedge clk_32);
		rom2_sel <= 1'b0;
		@(negedge clk_32);
		check(rom_addr, ca, "rom address without rom2");
	endtask

	task automatic mmu_cycle(input logic [ADDR_W:1] a, input logic we_n, input logic hit);
		logic [DATA_W-1:0] d;
		logic [1:0]        s;
		d = $random(seed);
		s = $random(seed);
		@(posedge clk_32);
		mmu.ras_n <= 1'b1;
		slot      <= SLOT_PRE;
		@(posedge clk_32);
		mmu <= '{addr: a, wdata: d, uds: s[1], lds: s[0], we_n: we_n, ras_n: 1'b0};
		@(negedge clk_32);
		check(sdram.oe, hit && we_n, "mmu read strobe");
		check(sdram.we, hit && !we_n, "mmu write strobe");
		check(sdram.addr, a, "mmu address");
		check(sdram.wdata, d, "mmu data");
		check({sdram.uds, sdram.lds}, s, "mmu byte strobes");
		@(negedge clk_32);
		check({sdram.oe, sdram.we}, 2'b00, "mmu strobe longer than one cycle");
		@(posedge clk_32);
		mmu.ras_n <= 1'b1;
	endtask

	task automatic mmu_window_test();
		logic [ADDR_W:1] a;
		for (int sz = 0; sz < 6; sz++) begin
			@(posedge clk_32);
			cfg.mem_size <= mem_size_e'(sz);
			a    = $random(seed);
			a    = a & window_mask(sz);
			a[1] = 1'b1; // keep it non-zero
			if (sz == 5)
				a[23] = 1'b1; // 14M reaches past the 8M limit
			mmu_cycle(a, 1'b1, 1'b1);
			mmu_cycle(a, 1'b0, 1'b1);
			a = $random(seed);
			a = a & window_mask(sz);
			if (sz < 5)
				a[19 + sz] = 1'b1; // first byte past the end of ram
			else
				a[23:21] = 3'b111; // $e00000 and up
			mmu_cycle(a, 1'b1, 1'b0);
			mmu_cycle(a, 1'b0, 1'b0);
		end
		mmu_cycle('0, 1'b1, 1'b0); // zero address never reads
	endtask

	task automatic master_test();
		logic [ADDR_W:1]   a;
		logic [DATA_W-1:0] d;
		a = $random(seed);
		d = $random(seed);
		@(posedge clk_32);
		slot   <= SLOT_CPU;
		mmu    <= '{addr: ~a, wdata: ~d, uds: 1'b0, lds: 1'b0, we_n: 1'b1, ras_n: 1'b1};
		master <= '{addr: a, wdata: d, has_bus: 1'b1, read: 1'b1, write: 1'b0};
		@(negedge clk_32);
		check({sdram.oe, sdram.we}, 2'b10, "blitter read strobes");
		check(sdram.addr, a, "blitter address");
		check(sdram.wdata, d, "blitter data");
		check({sdram.uds, sdram.lds}, 2'b11, "blitter byte strobes");
		@(posedge clk_32);
		master.read  <= 1'b0;
		master.write <= 1'b1;
		@(negedge clk_32);
		check({sdram.oe, sdram.we}, 2'b01, "blitter write strobes");
		@(posedge clk_32);
		master <= '0;
		slot   <= SLOT_VID;
	endtask

	task automatic cpu_access(input logic [5:0] base, input int n);
		logic [16:0] r17;
		repeat (n) begin
			r17 = $random(seed);
			@(posedge clk_32);
			cpu_addr <= {base, r17};
			cpu_as   <= 1'b1;
			mhz8_en  <= 1'b1;
			@(posedge clk_32);
			cpu_as   <= 1'b0;
			mhz8_en  <= 1'b0;
		end
	endtask

	task automatic viking_test(input logic steroids);
		logic [ADDR_W:1] va;
		logic [5:0]      base;
		int              cnt;
		va   = $random(seed);
		base = steroids ? 6'b111010 : 6'b110000; // $e8 or $c0
		apply_reset();
		@(posedge clk_32);
		slot <= SLOT_VID;
		if (steroids)
			cfg <= '{mem_size: MEM_14M, mode: MODE_STEROIDS, viking_req: 1'b0};
		else
			cfg <= '{mem_size: MEM_1M, mode: MODE_STE, viking_req: 1'b1};
		if (steroids)
			cpu_access(6'b110000, 260); // old base is ignored here
		cpu_access(base, 254);
		repeat (3) @(negedge clk_32);
		check(viking_active, 1'b0, "viking active too early");
		cpu_access(base, 1);
		cnt = 0;
		@(negedge clk_32);
		while (viking_active !== 1'b1) begin
			if (cnt == 8)
				report_timeout("viking_active_o after 255 accesses");
			cnt++;
			@(negedge clk_32);
		end
		@(posedge clk_32);
		viking_read <= 1'b1;
		viking_addr <= va;
		@(negedge clk_32);
		check(sdram.addr, va, "viking fetch address");
		check({sdram.oe, sdram.we}, 2'b10, "viking fetch strobes");
		@(posedge clk_32);
		viking_read <= 1'b0;
	endtask

	// hard stop in case a task never returns
	initial begin
		#200000;
		report_timeout("the end of the test sequence");
	end

	initial begin
		seed        = 32'hfb034e85;
		xsint       = 1'b0;
		cfg         = '{mem_size: MEM_1M, mode: MODE_STE, viking_req: 1'b0};
		slot        = SLOT_VID;
		mhz8_en     = 1'b0;
		mmu         = '{addr: '0, wdata: '0, uds: 1'b0, lds: 1'b0, we_n: 1'b1, ras_n: 1'b1};
		master      = '0;
		upload      = '0;
		cpu_addr    = '0;
		cpu_as      = 1'b0;
		rom2_sel    = 1'b0;
		viking_read = 1'b0;
		viking_addr = '0;
		apply_reset();
		upload_test();
		tos_flag_test(6'b111111, 1'b1); // $fcxxxx
		tos_flag_test(6'b111000, 1'b0); // $e0xxxx
		mmu_window_test();
		master_test();
		viking_test(1'b0);
		viking_test(1'b1);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
